//--- design/cgra_pkg.sv
package cgra_pkg;

	typedef logic [31:0] cfg_word_t;

	typedef enum logic [1:0] {
		SIDE_N = 2'd0,
		SIDE_E = 2'd1,
		SIDE_W = 2'd2,
		SIDE_S = 2'd3
	} side_t;

	// one 4-track bundle per side with north in the top bits.
	typedef struct packed {
		logic [3:0] n;
		logic [3:0] e;
		logic [3:0] w;
		logic [3:0] s;
	} tile_wires_t;

	typedef enum logic [1:0] {
		SB_SRC_0 = 2'd0, // source side (s+1+code) mod 4.
		SB_SRC_1 = 2'd1,
		SB_SRC_2 = 2'd2,
		SB_PE    = 2'd3
	} sb_code_t;

	typedef enum logic [2:0] {
		PE_AND    = 3'd0,
		PE_OR     = 3'd1,
		PE_XOR    = 3'd2,
		PE_NAND   = 3'd3,
		PE_PASS_A = 3'd4,
		PE_REG_A  = 3'd5
	} pe_op_t;

	typedef struct packed {
		logic [20:0] spare;
		logic [1:0]  b_track;
		side_t       b_side;
		logic [1:0]  a_track;
		side_t       a_side;
		pe_op_t      op;
	} pe_cfg_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [3:0] adr;
		cfg_word_t  dat;
	} wb_req_t;

	typedef struct packed {
		logic      ack;
		cfg_word_t dat;
	} wb_rsp_t;

	// source track is (t + offset) mod 4 with the table indexed [dst][src].
	localparam logic [1:0] track_offset [4][4] = '{
		'{2'd0, 2'd0, 2'd1, 2'd2},
		'{2'd3, 2'd0, 2'd0, 2'd2},
		'{2'd2, 2'd0, 2'd0, 2'd1},
		'{2'd3, 2'd0, 2'd2, 2'd0}
	};

	function automatic logic [3:0] wires_get(tile_wires_t w, side_t s);
		case (s)
			SIDE_N:  return w.n;
			SIDE_E:  return w.e;
			SIDE_W:  return w.w;
			default: return w.s;
		endcase
	endfunction

endpackage

//--- design/cgra_config_wb.sv
`timescale 1ns/1ps

module cgra_config_wb #(
	parameter int NUM_TILES = 2
) (
	input  logic                clk,
	input  logic                reset,
	input  cgra_pkg::wb_req_t   wb_i,
	output cgra_pkg::wb_rsp_t   wb_o,
	output logic [NUM_TILES-1:0] sb_we_o,
	output logic [NUM_TILES-1:0] pe_we_o,
	output cgra_pkg::cfg_word_t cfg_wdata_o,
	input  cgra_pkg::cfg_word_t sb_rdata_i [NUM_TILES],
	input  cgra_pkg::cfg_word_t pe_rdata_i [NUM_TILES]
);
	import cgra_pkg::*;

	logic      ack_q;
	cfg_word_t rdata_q;
	cfg_word_t rd_word;
	logic      take;
	logic      wr;

	// ack blocks a second take of a held request.
	assign take = wb_i.cyc && wb_i.stb && !ack_q;
	assign wr   = take && wb_i.we;

	assign cfg_wdata_o = wb_i.dat;

	// ##################################################
	// write decode
	// ##################################################

	always_comb begin
		sb_we_o = '0;
		pe_we_o = '0;
		for (int k = 0; k < NUM_TILES; k++) begin
			sb_we_o[k] = wr && (wb_i.adr == 4'(2 * k));
			pe_we_o[k] = wr && (wb_i.adr == 4'(2 * k + 1));
		end
	end

	// ##################################################
	// read-back mux
	// ##################################################

	always_comb begin
		rd_word = '0; // out of range reads zero.
		for (int k = 0; k < NUM_TILES; k++) begin
			if (wb_i.adr == 4'(2 * k))
				rd_word = sb_rdata_i[k];
			if (wb_i.adr == 4'(2 * k + 1))
				rd_word = pe_rdata_i[k];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= take; // single cycle pulse.
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			rdata_q <= wb_i.we ? '0 : rd_word;
		end
	end

	assign wb_o = '{ack: ack_q, dat: rdata_q};

endmodule

//--- design/cgra_switch_box.sv
`timescale 1ns/1ps

module cgra_switch_box (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_we_i,
	input  cgra_pkg::cfg_word_t   cfg_wdata_i,
	output cgra_pkg::cfg_word_t   cfg_o,
	input  cgra_pkg::tile_wires_t in_i,
	input  logic                  pe_out_i,
	output cgra_pkg::tile_wires_t out_o
);
	import cgra_pkg::*;

	cfg_word_t  cfg_q;
	logic [3:0] out_side [4];

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_wdata_i;
		end
	end

	assign cfg_o = cfg_q;

	// ##################################################
	// per-output track muxes
	// ##################################################

	// field for side s, track t at bits 2*(4s+t).
	always_comb begin
		sb_code_t   code;
		side_t      src_side;
		logic [1:0] src_track;
		logic [3:0] src_bus;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				code      = sb_code_t'(cfg_q[2 * (4 * s + t) +: 2]);
				src_side  = side_t'(2'(s + 1 + int'(code)));
				src_track = 2'(t + int'(track_offset[s][src_side]));
				src_bus   = wires_get(in_i, src_side);
				if (code == SB_PE)
					out_side[s][t] = pe_out_i;
				else
					out_side[s][t] = src_bus[src_track];
			end
		end
	end

	assign out_o = '{
		n: out_side[SIDE_N],
		e: out_side[SIDE_E],
		w: out_side[SIDE_W],
		s: out_side[SIDE_S]
	};

endmodule

//--- design/cgra_pe.sv
`timescale 1ns/1ps

module cgra_pe (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cfg_we_i,
	input  cgra_pkg::cfg_word_t   cfg_wdata_i,
	output cgra_pkg::cfg_word_t   cfg_o,
	input  cgra_pkg::tile_wires_t in_i,
	output logic                  pe_out_o
);
	import cgra_pkg::*;

	pe_cfg_t    cfg_q;
	logic [3:0] a_bus;
	logic [3:0] b_bus;
	logic       op_a;
	logic       op_b;
	logic       a_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= pe_cfg_t'(cfg_wdata_i);
		end
	end

	assign cfg_o = cfg_word_t'(cfg_q); // spare bits read back too.

	// ##################################################
	// operand select
	// ##################################################

	always_comb begin
		a_bus = wires_get(in_i, cfg_q.a_side);
		b_bus = wires_get(in_i, cfg_q.b_side);
		op_a  = a_bus[cfg_q.a_track];
		op_b  = b_bus[cfg_q.b_track];
	end

	// one cycle delay for PE_REG_A.
	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= 1'b0;
		end else begin
			a_q <= op_a;
		end
	end

	always_comb begin
		case (cfg_q.op)
			PE_AND:    pe_out_o = op_a & op_b;
			PE_OR:     pe_out_o = op_a | op_b;
			PE_XOR:    pe_out_o = op_a ^ op_b;
			PE_NAND:   pe_out_o = ~(op_a & op_b);
			PE_PASS_A: pe_out_o = op_a;
			PE_REG_A:  pe_out_o = a_q;
			default:   pe_out_o = 1'b0; // unused opcodes.
		endcase
	end

endmodule

//--- design/cgra_tile.sv
`timescale 1ns/1ps

module cgra_tile (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sb_we_i,
	input  logic                  pe_we_i,
	input  cgra_pkg::cfg_word_t   cfg_wdata_i,
	output cgra_pkg::cfg_word_t   sb_cfg_o,
	output cgra_pkg::cfg_word_t   pe_cfg_o,
	input  cgra_pkg::tile_wires_t in_i,
	output cgra_pkg::tile_wires_t out_o
);
	import cgra_pkg::*;

	logic pe_out;

	// PE sees the same incoming wires as the box.
	cgra_pe u_pe (
		.clk         (clk),
		.reset       (reset),
		.cfg_we_i    (pe_we_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_o       (pe_cfg_o),
		.in_i        (in_i),
		.pe_out_o    (pe_out)
	);

	cgra_switch_box u_sb (
		.clk         (clk),
		.reset       (reset),
		.cfg_we_i    (sb_we_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_o       (sb_cfg_o),
		.in_i        (in_i),
		.pe_out_i    (pe_out),
		.out_o       (out_o)
	);

endmodule

//--- design/cgra_row.sv
`timescale 1ns/1ps

module cgra_row #(
	parameter int NUM_TILES = 2
) (
	input  logic                        clk,
	input  logic                        reset,
	input  cgra_pkg::wb_req_t           wb_i,
	output cgra_pkg::wb_rsp_t           wb_o,
	input  logic [NUM_TILES-1:0][3:0]   north_i,
	output logic [NUM_TILES-1:0][3:0]   north_o,
	input  logic [NUM_TILES-1:0][3:0]   south_i,
	output logic [NUM_TILES-1:0][3:0]   south_o,
	input  logic [3:0]                  west_i,
	output logic [3:0]                  west_o,
	input  logic [3:0]                  east_i,
	output logic [3:0]                  east_o
);
	import cgra_pkg::*;

	logic [NUM_TILES-1:0] sb_we;
	logic [NUM_TILES-1:0] pe_we;
	cfg_word_t            cfg_wdata;
	cfg_word_t            sb_rdata [NUM_TILES];
	cfg_word_t            pe_rdata [NUM_TILES];
	tile_wires_t          tile_in  [NUM_TILES];
	tile_wires_t          tile_out [NUM_TILES];

	cgra_config_wb #(.NUM_TILES(NUM_TILES)) u_cfg (
		.clk         (clk),
		.reset       (reset),
		.wb_i        (wb_i),
		.wb_o        (wb_o),
		.sb_we_o     (sb_we),
		.pe_we_o     (pe_we),
		.cfg_wdata_o (cfg_wdata),
		.sb_rdata_i  (sb_rdata),
		.pe_rdata_i  (pe_rdata)
	);

	// ##################################################
	// tile chain
	// ##################################################

	for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
		logic [3:0] west_src;
		logic [3:0] east_src;

		if (k == 0) begin : g_west_edge
			assign west_src = west_i;
			assign west_o   = tile_out[k].w;
		end else begin : g_west_link
			assign west_src = tile_out[k-1].e; // from left neighbour.
		end

		if (k == NUM_TILES - 1) begin : g_east_edge
			assign east_src = east_i;
			assign east_o   = tile_out[k].e;
		end else begin : g_east_link
			assign east_src = tile_out[k+1].w;
		end

		assign tile_in[k] = '{n: north_i[k], e: east_src, w: west_src, s: south_i[k]};
		assign north_o[k] = tile_out[k].n;
		assign south_o[k] = tile_out[k].s;

		cgra_tile u_tile (
			.clk         (clk),
			.reset       (reset),
			.sb_we_i     (sb_we[k]),
			.pe_we_i     (pe_we[k]),
			.cfg_wdata_i (cfg_wdata),
			.sb_cfg_o    (sb_rdata[k]),
			.pe_cfg_o    (pe_rdata[k]),
			.in_i        (tile_in[k]),
			.out_o       (tile_out[k])
		);
	end

endmodule

//--- dv/cgra_row_assertions.sv
`timescale 1ns/1ps

module cgra_row_assertions (
	input logic              clk,
	input logic              reset,
	input cgra_pkg::wb_req_t req_i,
	input cgra_pkg::wb_rsp_t rsp_i
);

	int fail_count = 0; // read from the testbench top.

	// ##################################################
	// wishbone ack
	// ##################################################

	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		rsp_i.ack |=> !rsp_i.ack)
		else begin
			$error("ack stayed high for two cycles");
			fail_count++;
		end

	// no request, no ack.
	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		(!rsp_i.ack && !(req_i.cyc && req_i.stb)) |=> !rsp_i.ack)
		else begin
			$error("ack rose without cyc and stb");
			fail_count++;
		end

	a_ack_after_reset: assert property (@(posedge clk)
		reset |=> !rsp_i.ack)
		else begin
			$error("ack high in the cycle after reset");
			fail_count++;
		end

endmodule

//--- dv/cgra_row_tb.sv
`timescale 1ns/1ps

module cgra_row_tb;
	import cgra_pkg::*;

	localparam int NT = 2;
	localparam int NW = NT * 4;

	// source track is (t + offset) mod 4 with the table indexed [dst][src].
	localparam int route_offset [4][4] = '{
		'{0, 0, 1, 2},
		'{3, 0, 0, 2},
		'{2, 0, 0, 1},
		'{3, 0, 2, 0}
	};

	typedef enum {STEP_WRITE, STEP_READ, STEP_EDGE} step_kind_t;

	typedef struct {
		step_kind_t    kind;
		logic [3:0]    adr;
		cfg_word_t     dat; // write data or expected read word.
		logic [NW-1:0] north;
		logic [NW-1:0] south;
		logic [3:0]    west;
		logic [3:0]    east;
	} step_t;

	logic               clk;
	logic               reset;
	wb_req_t            wb_req;
	wb_rsp_t            wb_rsp;
	logic [NT-1:0][3:0] north_in;
	logic [NT-1:0][3:0] north_out;
	logic [NT-1:0][3:0] south_in;
	logic [NT-1:0][3:0] south_out;
	logic [3:0]         west_in;
	logic [3:0]         west_out;
	logic [3:0]         east_in;
	logic [3:0]         east_out;

	step_t       steps [$];
	bit          table_ready = 1'b0;
	cfg_word_t   model_cfg [2 * NT];
	logic        model_reg [NT];
	tile_wires_t m_out [NT];
	logic        m_op_a [NT];

	cgra_row #(.NUM_TILES(NT)) UUT (
		.clk     (clk),
		.reset   (reset),
		.wb_i    (wb_req),
		.wb_o    (wb_rsp),
		.north_i (north_in),
		.north_o (north_out),
		.south_i (south_in),
		.south_o (south_out),
		.west_i  (west_in),
		.west_o  (west_out),
		.east_i  (east_in),
		.east_o  (east_out)
	);

	bind cgra_config_wb cgra_row_assertions u_wb_checks (
		.clk   (clk),
		.reset (reset),
		.req_i (wb_i),
		.rsp_i (wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	initial begin
		wait (table_ready);
		repeat (steps.size() * 8 + 100) @(posedge clk);
		stop_with_failure("watchdog expired before the step table was done");
	end

	initial begin
		wait (UUT.u_cfg.u_wb_checks.fail_count != 0);
		stop_with_failure("a Wishbone assertion failed on the config bus");
	end

	// ##################################################
	// reference model
	// ##################################################

	function automatic logic bus_bit(tile_wires_t w, int side, int trk);
		logic [15:0] flat;
		flat = w;
		return flat[(3 - side) * 4 + trk];
	endfunction

	function automatic logic pe_operand(cfg_word_t cfg, tile_wires_t tin, bit is_b);
		if (is_b)
			return bus_bit(tin, int'(cfg[8:7]), int'(cfg[10:9]));
		return bus_bit(tin, int'(cfg[4:3]), int'(cfg[6:5]));
	endfunction

	function automatic logic pe_result(cfg_word_t cfg, tile_wires_t tin, logic reg_a);
		logic a;
		logic b;
		a = pe_operand(cfg, tin, 1'b0);
		b = pe_operand(cfg, tin, 1'b1);
		case (pe_op_t'(cfg[2:0]))
			PE_AND:    return a & b;
			PE_OR:     return a | b;
			PE_XOR:    return a ^ b;
			PE_NAND:   return ~(a & b);
			PE_PASS_A: return a;
			PE_REG_A:  return reg_a;
			default:   return 1'b0;
		endcase
	endfunction

	function automatic tile_wires_t route_sb(cfg_word_t cfg, tile_wires_t tin, logic pe);
		logic [15:0] flat;
		int          code;
		int          src;
		flat = '0;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				code = int'(cfg[2 * (4 * s + t) +: 2]);
				src  = (s + 1 + code) % 4;
				if (code == 3)
					flat[(3 - s) * 4 + t] = pe;
				else
					flat[(3 - s) * 4 + t] = bus_bit(tin, src, (t + route_offset[s][src]) % 4);
			end
		end
		return flat;
	endfunction

	// enough relaxation passes over the chain for any loop-free route.
	task automatic eval_model();
		tile_wires_t tin;
		logic        pe;
		for (int k = 0; k < NT; k++)
			m_out[k] = '0;
		repeat (8 * NT) begin
			for (int k = 0; k < NT; k++) begin
				tin.n = north_in[k];
				tin.s = south_in[k];
				if (k == 0)
					tin.w = west_in;
				else
					tin.w = m_out[k - 1].e;
				if (k == NT - 1)
					tin.e = east_in;
				else
					tin.e = m_out[k + 1].w;
				m_op_a[k] = pe_operand(model_cfg[2 * k + 1], tin, 1'b0);
				pe        = pe_result(model_cfg[2 * k + 1], tin, model_reg[k]);
				m_out[k]  = route_sb(model_cfg[2 * k], tin, pe);
			end
		end
	endtask

	// every clock edge goes through here so the modelled flop tracks the DUT.
	task automatic next_edge();
		@(posedge clk);
		eval_model();
		for (int k = 0; k < NT; k++)
			model_reg[k] = m_op_a[k];
	endtask

	// ##################################################
	// checks and bus access
	// ##################################################

	task automatic check_read(input string name, input wb_rsp_t got, input cfg_word_t exp);
		if (got.dat !== exp)
			stop_with_failure($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
				$time, name, got.dat, exp));
	endtask

	task automatic check_edges(input string name, input tile_wires_t got,
			input tile_wires_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
	endtask

	task automatic wb_cycle(input logic we, input logic [3:0] adr, input cfg_word_t dat,
			output wb_rsp_t rsp);
		int n;
		n = 0;
		next_edge();
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do begin
			next_edge();
			@(negedge clk);
			n++;
		end while (!wb_rsp.ack && n < 4);
		if (!wb_rsp.ack)
			stop_with_failure($sformatf("no ack from the config slave at %0t", $time));
		if (n != 1)
			stop_with_failure($sformatf("ack came %0d cycles after the request at %0t",
				n, $time));
		if (we && adr < 4'(2 * NT))
			model_cfg[adr] = dat; // loaded on the ack edge.
		rsp = wb_rsp;
		next_edge();
		wb_req <= '0;
	endtask

	task automatic apply_step(input step_t st);
		wb_rsp_t     rsp;
		tile_wires_t got;
		tile_wires_t exp;
		case (st.kind)
			STEP_WRITE: wb_cycle(1'b1, st.adr, st.dat, rsp);
			STEP_READ: begin
				wb_cycle(1'b0, st.adr, '0, rsp);
				check_read($sformatf("wb_o.dat adr %0d", st.adr), rsp, st.dat);
			end
			default: begin
				next_edge();
				north_in <= st.north;
				south_in <= st.south;
				west_in  <= st.west;
				east_in  <= st.east;
				@(negedge clk);
				eval_model();
				for (int k = 0; k < NT; k++) begin
					got   = '0;
					exp   = '0;
					got.n = north_out[k];
					got.s = south_out[k];
					exp.n = m_out[k].n;
					exp.s = m_out[k].s;
					if (k == 0) begin
						got.w = west_out;
						exp.w = m_out[k].w;
					end
					if (k == NT - 1) begin
						got.e = east_out;
						exp.e = m_out[k].e;
					end
					check_edges($sformatf("edge outputs of tile %0d", k), got, exp);
				end
			end
		endcase
	endtask

	// ##################################################
	// step table
	// ##################################################

	// crossing outputs never take the PE so no route can loop.
	function automatic cfg_word_t rand_sb_word(int k, bit allow_pe);
		cfg_word_t w;
		bit        crossing;
		w = '0;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				crossing = (s == 1 && k < NT - 1) || (s == 2 && k > 0);
				if (allow_pe && !crossing)
					w[2 * (4 * s + t) +: 2] = 2'($urandom_range(3, 0));
				else
					w[2 * (4 * s + t) +: 2] = 2'($urandom_range(2, 0));
			end
		end
		return w;
	endfunction

	function automatic cfg_word_t rand_pe_word(pe_op_t op);
		return ($urandom() & 32'hffff_fff8) | cfg_word_t'(op);
	endfunction

	task automatic add_wb(step_kind_t kind, int adr, cfg_word_t dat);
		step_t st;
		st.kind  = kind;
		st.adr   = 4'(adr);
		st.dat   = dat;
		st.north = '0;
		st.south = '0;
		st.west  = '0;
		st.east  = '0;
		steps.push_back(st);
	endtask

	task automatic add_edges(int n);
		step_t st;
		repeat (n) begin
			st.kind  = STEP_EDGE;
			st.adr   = '0;
			st.dat   = '0;
			st.north = NW'($urandom());
			st.south = NW'($urandom());
			st.west  = 4'($urandom());
			st.east  = 4'($urandom());
			steps.push_back(st);
		end
	endtask

	task automatic add_pe_setup(pe_op_t op);
		cfg_word_t sb;
		for (int k = 0; k < NT; k++) begin
			add_wb(STEP_WRITE, 2 * k + 1, rand_pe_word(op));
			sb      = rand_sb_word(k, 1'b1);
			sb[1:0] = SB_PE; // north track 0 shows the PE.
			add_wb(STEP_WRITE, 2 * k, sb);
		end
	endtask

	task automatic build_table();
		cfg_word_t w [2 * NT];
		add_edges(6); // reset routes.
		for (int i = 0; i < 2 * NT; i++) begin
			if (i % 2 == 0)
				w[i] = rand_sb_word(i / 2, 1'b1);
			else
				w[i] = rand_pe_word(PE_REG_A);
			add_wb(STEP_WRITE, i, w[i]);
		end
		for (int i = 0; i < 2 * NT; i++)
			add_wb(STEP_READ, i, w[i]);
		add_wb(STEP_READ, 2 * NT + 1, '0);
		add_wb(STEP_WRITE, 2 * NT + 1, $urandom());
		for (int i = 0; i < 2 * NT; i++)
			add_wb(STEP_READ, i, w[i]);
		repeat (3) begin
			for (int k = 0; k < NT; k++)
				add_wb(STEP_WRITE, 2 * k, rand_sb_word(k, 1'b0));
			add_edges(4);
		end
		for (int op = 0; op <= int'(PE_PASS_A); op++) begin
			add_pe_setup(pe_op_t'(op));
			add_edges(4);
		end
		add_pe_setup(PE_REG_A);
		add_edges(8);
	endtask

	initial begin
		reset    = 1'b1;
		wb_req   = '0;
		north_in = '0;
		south_in = '0;
		west_in  = '0;
		east_in  = '0;
		for (int i = 0; i < 2 * NT; i++)
			model_cfg[i] = '0;
		for (int k = 0; k < NT; k++)
			model_reg[k] = 1'b0;
		void'($urandom(51966));
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		foreach (steps[i])
			apply_step(steps[i]);
		if (UUT.u_cfg.u_wb_checks.fail_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			stop_with_failure("a Wishbone assertion failed during the run");
		end
	end

endmodule

//--- flist.f
design/cgra_pkg.sv
design/cgra_config_wb.sv
design/cgra_switch_box.sv
design/cgra_pe.sv
design/cgra_tile.sv
design/cgra_row.sv
dv/cgra_row_assertions.sv
dv/cgra_row_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cgra_row_tb -f flist.f -o cgra_row_sim

# tee keeps the log even when the run stops early.
./obj_dir/cgra_row_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation ok, see sim.log"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
